// ==== alu_pkg.sv ====
// integer ALU package
// operation and size encodings, thread id and datapath widths
package alu_pkg;

  localparam int data_width = 64;
  localparam int half_width = data_width / 2; // 32-bit op boundary

  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    XNOR  = 4'd5,
    MOV   = 4'd6,
    ZXT8  = 4'd7,
    ZXT16 = 4'd8,
    SXT8  = 4'd9,
    SXT16 = 4'd10,
    SXT32 = 4'd11,
    CMOV  = 4'd12, // b if cond holds, else a
    CSET  = 4'd13
  } alu_op_e;

  // only ADD through MOV look at the size
  typedef enum logic {
    SZ32 = 1'b0,
    SZ64 = 1'b1
  } op_size_e;

  typedef logic thread_t; // two hardware threads

endpackage

// ==== flags_pkg.sv ====
// flags package
// flag set layout, condition codes and flag constants
package flags_pkg;

  // same bit order as the architectural COASZP field
  typedef struct packed {
    logic c;
    logic o;
    logic a; // nibble carry
    logic s;
    logic z;
    logic p;
  } flags_t;

  localparam int flags_width = $bits(flags_t);
  localparam int parity_bits = 8; // parity covers the low byte only
  localparam flags_t flags_none = '0;

  typedef enum logic [3:0] {
    Z   = 4'd0,
    NZ  = 4'd1,
    S   = 4'd2,
    NS  = 4'd3,
    UGT = 4'd4,
    ULE = 4'd5,
    UGE = 4'd6,
    ULT = 4'd7,
    SGT = 4'd8,
    SLE = 4'd9,
    SGE = 4'd10,
    SLT = 4'd11,
    O   = 4'd12,
    NO  = 4'd13,
    P   = 4'd14,
    NP  = 4'd15
  } cond_e;

endpackage

// ==== alu_stage_if.sv ====
// execute to retire stage bundle
// valid qualifies the rest in the same cycle
`timescale 1ns/100ps

interface alu_stage_if;
  import alu_pkg::*;
  import flags_pkg::*;

  logic valid;
  alu_op_e op;
  op_size_e size;
  thread_t thread;
  logic [data_width-1:0] result;
  flags_t raw_flags; // c, o, a only

  modport exec (
    output valid, op, size, thread, result, raw_flags
  );

  modport retire (
    input valid, op, size, thread, result, raw_flags
  );

endinterface

// ==== cond_eval.sv ====
// condition evaluator
// checks one condition code against a flag set
`timescale 1ns/100ps

module cond_eval (
  input  flags_pkg::flags_t flags,
  input  flags_pkg::cond_e  cond,
  output logic              taken
);
  import flags_pkg::*;

  logic sign_ne_ovf;

  assign sign_ne_ovf = flags.s ^ flags.o;

  always_comb
  begin
    case (cond)
      Z:   taken = flags.z;
      NZ:  taken = ~flags.z;
      S:   taken = flags.s;
      NS:  taken = ~flags.s;
      UGT: taken = ~flags.c & ~flags.z;
      ULE: taken = flags.c | flags.z;
      UGE: taken = ~flags.c; // c is a borrow after sub
      ULT: taken = flags.c;
      SGT: taken = ~flags.z & ~sign_ne_ovf;
      SLE: taken = flags.z | sign_ne_ovf;
      SGE: taken = ~sign_ne_ovf;
      SLT: taken = sign_ne_ovf;
      O:   taken = flags.o;
      NO:  taken = ~flags.o;
      P:   taken = flags.p;
      NP:  taken = ~flags.p;
      default: taken = 1'b0;
    endcase
  end

endmodule

// ==== alu_adder.sv ====
// add/subtract datapath
// carry, nibble carry and overflow tapped at the op size
`timescale 1ns/100ps

module alu_adder (
  input  logic [alu_pkg::data_width-1:0] a,
  input  logic [alu_pkg::data_width-1:0] b,
  input  logic                           subtract,
  input  alu_pkg::op_size_e              size,
  output logic [alu_pkg::data_width-1:0] sum,
  output logic                           carry,
  output logic                           half_carry,
  output logic                           overflow
);
  import alu_pkg::*;

  logic [data_width-1:0] b_eff;
  logic [data_width:0] total;
  logic carry_4;
  logic carry_half;
  logic carry_full;
  logic sign_a;
  logic sign_b;
  logic sign_s;

  assign b_eff = subtract ? ~b : b; // sub is a + ~b + 1
  assign total = {1'b0, a} + {1'b0, b_eff} + {{data_width{1'b0}}, subtract};
  assign sum = total[data_width-1:0];

  // carry into bit k is sum ^ a ^ b at that bit
  assign carry_4 = sum[4] ^ a[4] ^ b_eff[4];
  assign carry_half = sum[half_width] ^ a[half_width] ^ b_eff[half_width];
  assign carry_full = total[data_width];

  assign sign_a = (size == SZ64) ? a[data_width-1] : a[half_width-1];
  assign sign_b = (size == SZ64) ? b_eff[data_width-1] : b_eff[half_width-1];
  assign sign_s = (size == SZ64) ? sum[data_width-1] : sum[half_width-1];

  // invert carries into borrows for sub
  assign carry = ((size == SZ64) ? carry_full : carry_half) ^ subtract;
  assign half_carry = carry_4 ^ subtract;
  assign overflow = (sign_a == sign_b) && (sign_s != sign_a);

endmodule

// ==== alu_exec.sv ====
// ALU execute stage
// op decode, result select and raw c/o/a flags, all combinational
`timescale 1ns/100ps

module alu_exec (
  input  logic                           op_valid,
  input  alu_pkg::alu_op_e               op,
  input  alu_pkg::op_size_e              size,
  input  alu_pkg::thread_t               thread,
  input  logic [alu_pkg::data_width-1:0] a,
  input  logic [alu_pkg::data_width-1:0] b,
  input  flags_pkg::cond_e               cond,
  input  flags_pkg::flags_t              flags_in,
  alu_stage_if.exec                      stage
);
  import alu_pkg::*;
  import flags_pkg::*;

  logic add_en;
  logic subtract;
  logic sized_op;
  logic taken;
  logic carry;
  logic half_carry;
  logic overflow;
  logic [data_width-1:0] sum;
  logic [data_width-1:0] res_raw;

  assign add_en = (op == ADD) || (op == SUB);
  assign subtract = (op == SUB);
  assign sized_op = op inside {ADD, SUB, AND, OR, XOR, XNOR, MOV};

  alu_adder u_adder (
    .a          (a),
    .b          (b),
    .subtract   (subtract),
    .size       (size),
    .sum        (sum),
    .carry      (carry),
    .half_carry (half_carry),
    .overflow   (overflow)
  );

  cond_eval u_cond (
    .flags (flags_in),
    .cond  (cond),
    .taken (taken)
  );

  always_comb
  begin
    case (op)
      ADD, SUB: res_raw = sum;
      AND:      res_raw = a & b;
      OR:       res_raw = a | b;
      XOR:      res_raw = a ^ b;
      XNOR:     res_raw = ~(a ^ b);
      MOV:      res_raw = b;
      ZXT8:     res_raw = {{(data_width-8){1'b0}}, b[7:0]};
      ZXT16:    res_raw = {{(data_width-16){1'b0}}, b[15:0]};
      SXT8:     res_raw = {{(data_width-8){b[7]}}, b[7:0]};
      SXT16:    res_raw = {{(data_width-16){b[15]}}, b[15:0]};
      SXT32:    res_raw = {{(data_width-32){b[31]}}, b[31:0]};
      CMOV:     res_raw = taken ? b : a;
      CSET:     res_raw = {{(data_width-1){1'b0}}, taken};
      default:  res_raw = '0;
    endcase
  end

  assign stage.valid = op_valid;
  assign stage.op = op;
  assign stage.size = size;
  assign stage.thread = thread;
  assign stage.result = (sized_op && size == SZ32) ?
                        {{half_width{1'b0}}, res_raw[half_width-1:0]} : res_raw;
  // s, z, p come later from the registered result
  assign stage.raw_flags = add_en ?
                           flags_t'{c: carry, o: overflow, a: half_carry, default: 1'b0} :
                           flags_none;

  always_comb
  begin
    if (op_valid)
    begin
      assert #0 (!$isunknown(op))
        else $error("alu_exec: op has unknown bits while op_valid is high");
    end
  end

endmodule

// ==== alu_retire.sv ====
// ALU retire stage
// one register stage with thread flush filtering and s/z/p flags
`timescale 1ns/100ps

module alu_retire (
  input  logic                           clk,
  input  logic                           rst,
  alu_stage_if.retire                    stage,
  input  logic                           flush,
  input  alu_pkg::thread_t               flush_thread,
  output logic                           res_valid,
  output logic [alu_pkg::data_width-1:0] result,
  output logic                           flags_valid,
  output flags_pkg::flags_t              flags
);
  import alu_pkg::*;
  import flags_pkg::*;

  logic sets_flags;
  logic killed;
  logic flush_q;
  thread_t flush_thread_q;
  op_size_e size_q;
  flags_t raw_q;
  logic [data_width-1:0] result_q;
  logic sign_bit;
  logic zero_bit;
  logic parity_bit;

  assign sets_flags = stage.op inside {ADD, SUB, AND, OR, XOR, XNOR};

  // flush this edge or the edge before
  assign killed = (flush && flush_thread == stage.thread) ||
                  (flush_q && flush_thread_q == stage.thread);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      res_valid <= 1'b0;
      flags_valid <= 1'b0;
      result_q <= '0;
      flush_q <= 1'b0;
      flush_thread_q <= 1'b0;
    end
    else
    begin
      res_valid <= stage.valid && !killed;
      flags_valid <= stage.valid && !killed && sets_flags;
      flush_q <= flush;
      flush_thread_q <= flush_thread;
      if (stage.valid && !killed)
        result_q <= stage.result; // hold last retired value
    end
  end

  always_ff @(posedge clk)
  begin
    if (stage.valid)
    begin
      size_q <= stage.size;
      raw_q <= stage.raw_flags;
    end
  end

  assign result = result_q;

  assign sign_bit = (size_q == SZ64) ? result_q[data_width-1] : result_q[half_width-1];
  assign zero_bit = (size_q == SZ64) ? (result_q == '0) : (result_q[half_width-1:0] == '0);
  assign parity_bit = ~^result_q[parity_bits-1:0]; // even number of ones

  assign flags = flags_valid ?
                 flags_t'{c: raw_q.c, o: raw_q.o, a: raw_q.a,
                          s: sign_bit, z: zero_bit, p: parity_bit} :
                 flags_none;

  a_flags_with_result: assert property (
    @(posedge clk) disable iff (rst) flags_valid |-> res_valid
  ) else $error("alu_retire: flags_valid without res_valid");

  a_quiet_after_reset: assert property (
    @(posedge clk) rst |=> !res_valid
  ) else $error("alu_retire: res_valid high in the cycle after reset");

endmodule

// ==== alu_top.sv ====
// integer ALU top level
// execute stage feeding a one-cycle retire stage
`timescale 1ns/100ps

module alu_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                op_valid,
  input  alu_pkg::alu_op_e                    op,
  input  alu_pkg::op_size_e                   size,
  input  alu_pkg::thread_t                    thread,
  input  logic [alu_pkg::data_width-1:0]      a,
  input  logic [alu_pkg::data_width-1:0]      b,
  input  flags_pkg::cond_e                    cond,
  input  logic [flags_pkg::flags_width-1:0]   flags_in,
  input  logic                                flush,
  input  alu_pkg::thread_t                    flush_thread,
  output logic                                res_valid,
  output logic [alu_pkg::data_width-1:0]      result,
  output logic                                flags_valid,
  output logic [flags_pkg::flags_width-1:0]   flags
);

  alu_stage_if stage ();

  alu_exec u_exec (
    .op_valid (op_valid),
    .op       (op),
    .size     (size),
    .thread   (thread),
    .a        (a),
    .b        (b),
    .cond     (cond),
    .flags_in (flags_in),
    .stage    (stage.exec)
  );

  alu_retire u_retire (
    .clk          (clk),
    .rst          (rst),
    .stage        (stage.retire),
    .flush        (flush),
    .flush_thread (flush_thread),
    .res_valid    (res_valid),
    .result       (result),
    .flags_valid  (flags_valid),
    .flags        (flags)
  );

endmodule

// ==== tb_alu.sv ====
// testbench for the integer ALU
// random ops checked against a behavioral model by concurrent assertions
`timescale 1ns/100ps

module tb_alu;
  import alu_pkg::*;
  import flags_pkg::*;

  typedef struct packed {
    logic [31:0] issue_cycle;
    logic [3:0] phase;
    logic killed;
    logic fv;
    logic [data_width-1:0] result;
    logic [flags_width-1:0] flags;
  } entry_t;

  logic clk;
  logic rst;
  logic op_valid;
  alu_op_e op;
  op_size_e size;
  thread_t thread;
  logic [data_width-1:0] a;
  logic [data_width-1:0] b;
  cond_e cond;
  logic [flags_width-1:0] flags_in;
  logic flush;
  thread_t flush_thread;
  logic res_valid;
  logic [data_width-1:0] result;
  logic flags_valid;
  logic [flags_width-1:0] flags;

  entry_t exp_q[$];
  entry_t cur;
  int unsigned cyc = 0;
  logic prev_flush;
  thread_t prev_flush_thread;
  logic exp_valid;
  logic exp_fv;
  logic [data_width-1:0] exp_result;
  logic [flags_width-1:0] exp_flags;
  logic [3:0] exp_phase;

  alu_top u_alu_top (
    .clk          (clk),
    .rst          (rst),
    .op_valid     (op_valid),
    .op           (op),
    .size         (size),
    .thread       (thread),
    .a            (a),
    .b            (b),
    .cond         (cond),
    .flags_in     (flags_in),
    .flush        (flush),
    .flush_thread (flush_thread),
    .res_valid    (res_valid),
    .result       (result),
    .flags_valid  (flags_valid),
    .flags        (flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  function automatic string phase_name(logic [3:0] ph);
    case (ph)
      4'd1: return "reset";
      4'd2: return "arith";
      4'd3: return "logic_move_ext";
      4'd4: return "cond_ops";
      4'd5: return "throughput";
      default: return "flush";
    endcase
  endfunction

  // even codes are the base test, odd codes its inverse
  function automatic logic cond_holds(cond_e cc, flags_t f);
    logic base;
    case (cc[3:1])
      3'd0: base = f.z;
      3'd1: base = f.s;
      3'd2: base = !f.c && !f.z; // above
      3'd3: base = !f.c;
      3'd4: base = !f.z && (f.s == f.o);
      3'd5: base = f.s == f.o;
      3'd6: base = f.o;
      default: base = f.p;
    endcase
    return base ^ cc[0];
  endfunction

  function automatic entry_t model_op(alu_op_e mop, op_size_e msz, logic [63:0] ma,
                                      logic [63:0] mb, cond_e mc, flags_t mf);
    entry_t e;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [64:0] wide;
    logic signed [65:0] xa;
    logic signed [65:0] xb;
    logic signed [65:0] exact;
    logic signed [65:0] smax;
    logic signed [65:0] smin;
    logic [63:0] r;
    logic c;
    logic o;
    logic h;
    int top;
    top = (msz == SZ64) ? 63 : 31;
    sa = (msz == SZ64) ? ma : {32'b0, ma[31:0]};
    sb = (msz == SZ64) ? mb : {32'b0, mb[31:0]};
    wide = {1'b0, sa} + {1'b0, sb};
    // operands as signed numbers of the op size
    xa = (msz == SZ64) ? 66'($signed(ma)) : 66'($signed(ma[31:0]));
    xb = (msz == SZ64) ? 66'($signed(mb)) : 66'($signed(mb[31:0]));
    smax = (66'sd1 <<< top) - 66'sd1;
    smin = -(66'sd1 <<< top);
    exact = '0;
    c = 1'b0;
    o = 1'b0;
    h = 1'b0;
    e = '0;
    case (mop)
      ADD:
      begin
        r = wide[63:0];
        c = wide[top + 1];
        exact = xa + xb;
        o = (exact > smax) || (exact < smin); // out of signed range
        h = ({1'b0, ma[3:0]} + {1'b0, mb[3:0]}) > 5'd15;
      end
      SUB:
      begin
        r = sa - sb;
        c = sa < sb; // borrow
        exact = xa - xb;
        o = (exact > smax) || (exact < smin);
        h = ma[3:0] < mb[3:0];
      end
      AND:   r = ma & mb;
      OR:    r = ma | mb;
      XOR:   r = ma ^ mb;
      XNOR:  r = ~(ma ^ mb);
      MOV:   r = mb;
      ZXT8:  r = 64'(mb[7:0]);
      ZXT16: r = 64'(mb[15:0]);
      SXT8:  r = 64'($signed(mb[7:0]));
      SXT16: r = 64'($signed(mb[15:0]));
      SXT32: r = 64'($signed(mb[31:0]));
      CMOV:  r = cond_holds(mc, mf) ? mb : ma;
      CSET:  r = 64'(cond_holds(mc, mf));
      default: r = '0;
    endcase
    if ((mop inside {ADD, SUB, AND, OR, XOR, XNOR, MOV}) && msz == SZ32)
      r[63:32] = '0;
    e.result = r;
    e.fv = mop inside {ADD, SUB, AND, OR, XOR, XNOR};
    if (e.fv)
      e.flags = {c, o, h, r[top], r == 64'd0, ($countones(r[7:0]) % 2) == 0};
    return e;
  endfunction

  function automatic logic [63:0] pick_operand();
    case ($urandom % 12)
      0: return 64'd0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'h7fff_ffff_ffff_ffff;
      4: return 64'h0000_0000_8000_0000;
      5: return 64'h0000_0000_7fff_ffff;
      6: return 64'h0000_0000_ffff_ffff;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  task automatic next_cycle();
    prev_flush = flush;
    prev_flush_thread = flush_thread;
    @(posedge clk);
    #1;
    op_valid = 1'b0;
    flush = 1'b0;
  endtask

  // flush for this edge must already be on the pins
  task automatic issue(alu_op_e iop, op_size_e isz, thread_t ith, logic [63:0] ia,
                       logic [63:0] ib, cond_e icc, logic [5:0] ifl, int ph);
    entry_t e;
    op_valid = 1'b1;
    op = iop;
    size = isz;
    thread = ith;
    a = ia;
    b = ib;
    cond = icc;
    flags_in = ifl;
    e = model_op(iop, isz, ia, ib, icc, ifl);
    e.issue_cycle = cyc + 1;
    e.phase = 4'(ph);
    e.killed = (flush && flush_thread == ith) || (prev_flush && prev_flush_thread == ith);
    exp_q.push_back(e);
    next_cycle();
  endtask

  task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
    $display("FAILED %s %s: expected %h, actual %h", phase_name(exp_phase), what,
             expected, actual);
    $display("Finished with errors");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 10)
    begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout: issued ops never retired within 10 cycles");
      $display("Finished with errors");
      $fatal(1, "drain timeout");
    end
    next_cycle(); // last compare
  endtask

  // expected outputs for the coming edge
  always @(negedge clk)
  begin
    exp_valid = 1'b0;
    exp_fv = 1'b0;
    exp_result = '0;
    exp_flags = '0;
    if (exp_q.size() > 0 && exp_q[0].issue_cycle == cyc)
    begin
      cur = exp_q.pop_front();
      exp_phase = cur.phase;
      exp_valid = !cur.killed;
      exp_fv = !cur.killed && cur.fv;
      exp_result = cur.result;
      if (exp_fv)
        exp_flags = cur.flags;
    end
  end

  a_res_valid: assert property (@(posedge clk) disable iff (rst) res_valid == exp_valid)
    else report_mismatch("res_valid", $sampled(exp_valid), $sampled(res_valid));
  a_result: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> result == exp_result)
    else report_mismatch("result", $sampled(exp_result), $sampled(result));
  a_flags_valid: assert property (@(posedge clk) disable iff (rst) flags_valid == exp_fv)
    else report_mismatch("flags_valid", $sampled(exp_fv), $sampled(flags_valid));
  a_flags: assert property (@(posedge clk) disable iff (rst) flags == exp_flags)
    else report_mismatch("flags", $sampled(exp_flags), $sampled(flags));

  initial
  begin
    rst = 1'b1;
    op_valid = 1'b0;
    op = ADD;
    size = SZ64;
    thread = 1'b0;
    a = '0;
    b = '0;
    cond = Z;
    flags_in = '0;
    flush = 1'b0;
    flush_thread = 1'b0;
    prev_flush = 1'b0;
    prev_flush_thread = 1'b0;
    exp_phase = 4'd1;
    void'($urandom(43941));
    repeat (16) next_cycle();
    rst = 1'b0;
    repeat (4) next_cycle(); // outputs stay quiet
    for (int i = 0; i < 80; i++)
    begin
      issue(($urandom % 2) ? SUB : ADD, op_size_e'($urandom % 2), 1'($urandom),
            pick_operand(), pick_operand(), Z, 6'd0, 2);
      if ($urandom % 4 == 0)
        next_cycle();
    end
    for (int i = 0; i < 60; i++)
    begin
      issue(alu_op_e'(2 + $urandom % 10), op_size_e'($urandom % 2), 1'($urandom),
            pick_operand(), pick_operand(), Z, 6'd0, 3);
      if ($urandom % 4 == 0)
        next_cycle();
    end
    for (int cc = 0; cc < 16; cc++)
      for (int k = 0; k < 4; k++)
        issue(k[0] ? CSET : CMOV, op_size_e'($urandom % 2), 1'($urandom),
              pick_operand(), pick_operand(), cond_e'(cc), 6'($urandom), 4);
    for (int i = 0; i < 40; i++)
      issue(alu_op_e'($urandom % 14), op_size_e'($urandom % 2), 1'($urandom),
            pick_operand(), pick_operand(), cond_e'($urandom % 16), 6'($urandom), 5);
    for (int i = 0; i < 60; i++)
    begin
      flush = ($urandom % 3) == 0;
      flush_thread = 1'($urandom);
      issue(alu_op_e'($urandom % 14), op_size_e'($urandom % 2), 1'($urandom),
            pick_operand(), pick_operand(), cond_e'($urandom % 16), 6'($urandom), 6);
    end
    wait_drain();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== flist.f ====
alu_pkg.sv
flags_pkg.sv
alu_stage_if.sv
cond_eval.sv
alu_adder.sv
alu_exec.sv
alu_retire.sv
alu_top.sv
tb_alu.sv

// ==== Bender.yml ====
package:
  name: int_alu

sources:
  - alu_pkg.sv
  - flags_pkg.sv
  - alu_stage_if.sv
  - cond_eval.sv
  - alu_adder.sv
  - alu_exec.sv
  - alu_retire.sv
  - alu_top.sv
  - target: test
    files:
      - tb_alu.sv
